/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - common/mipsPkg.sv
  - rtl/fetchStage.sv
  - decode/registerFile.sv
  - decode/decodeStage.sv
  - execute/executeStage.sv
  - rtl/hazardUnit.sv
  - rtl/writebackStage.sv
  - rtl/mipsPipeline.sv
  - target: simulation
    files:
      - sim/tbMipsPipeline.sv

/* build.f */
common/mipsPkg.sv
rtl/fetchStage.sv
decode/registerFile.sv
decode/decodeStage.sv
execute/executeStage.sv
rtl/hazardUnit.sv
rtl/writebackStage.sv
rtl/mipsPipeline.sv
sim/tbMipsPipeline.sv

/* common/mipsPkg.sv */
package mipsPkg;

    ////////////////////
    // widths and reset values
    localparam int WORD_W = 32;
    localparam int REG_COUNT = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] regAddr_t;
    // byte address without the two low bits
    typedef logic [WORD_W-3:0] wordAddr_t;

    localparam word_t RESET_PC = '0;
    // one instruction is four bytes
    localparam word_t PC_STEP = 32'd4;

    ////////////////////
    // instruction fields
    localparam int OPCODE_HI = 31;
    localparam int OPCODE_LO = 26;
    localparam int RS_HI = 25;
    localparam int RS_LO = 21;
    localparam int RT_HI = 20;
    localparam int RT_LO = 16;
    localparam int RD_HI = 15;
    localparam int RD_LO = 11;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;
    localparam int FUNCT_HI = 5;
    localparam int FUNCT_LO = 0;

    ////////////////////
    // encodings
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOp_e;

    // operand source in execute
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwdSel_e;

endpackage

/* decode/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              freeze,
    input  logic              stallDecode,
    input  logic              flushExecute,
    input  mipsPkg::word_t    instr,
    input  mipsPkg::word_t    pcPlus4,
    input  logic              regWriteWb,
    input  mipsPkg::regAddr_t writeRegWb,
    input  mipsPkg::word_t    writeDataWb,
    output mipsPkg::aluOp_e   aluOpEx,
    output logic              aluSrcImmEx,
    output logic              memReadEx,
    output logic              memWriteEx,
    output logic              regWriteEx,
    output logic              branchEx,
    output mipsPkg::word_t    operandAEx,
    output mipsPkg::word_t    operandBEx,
    output mipsPkg::word_t    immEx,
    output mipsPkg::regAddr_t writeRegEx,
    output mipsPkg::regAddr_t rsEx,
    output mipsPkg::regAddr_t rtEx,
    output mipsPkg::word_t    branchTargetEx,
    output logic              memToRegEx
);

    mipsPkg::opcode_e opcode;
    mipsPkg::funct_e funct;
    mipsPkg::regAddr_t rs, rt, rd;
    mipsPkg::word_t imm, readA, readB;
    mipsPkg::aluOp_e aluOp;
    logic aluSrcImm, memRead, memWrite, regWrite, branch, regDstRd;
    logic insertBubble;

    assign opcode = mipsPkg::opcode_e'(instr[mipsPkg::OPCODE_HI:mipsPkg::OPCODE_LO]);
    assign funct = mipsPkg::funct_e'(instr[mipsPkg::FUNCT_HI:mipsPkg::FUNCT_LO]);
    assign rs = instr[mipsPkg::RS_HI:mipsPkg::RS_LO];
    assign rt = instr[mipsPkg::RT_HI:mipsPkg::RT_LO];
    assign rd = instr[mipsPkg::RD_HI:mipsPkg::RD_LO];
    assign imm = {{(mipsPkg::WORD_W - mipsPkg::IMM_HI - 1){instr[mipsPkg::IMM_HI]}},
                  instr[mipsPkg::IMM_HI:mipsPkg::IMM_LO]};

    ////////////////////
    // main control
    always_comb begin
        aluOp = mipsPkg::ALU_ADD;
        aluSrcImm = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        branch = 1'b0;
        regDstRd = 1'b0;
        case (opcode)
            mipsPkg::OP_RTYPE: begin
                regDstRd = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    mipsPkg::FN_ADD: aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUB: aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND: aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:  aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_SLT: aluOp = mipsPkg::ALU_SLT;
                    // unknown function code, no write
                    default: regWrite = 1'b0;
                endcase
            end
            mipsPkg::OP_ADDI: begin
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
            end
            mipsPkg::OP_LW: begin
                aluSrcImm = 1'b1;
                memRead = 1'b1;
                regWrite = 1'b1;
            end
            mipsPkg::OP_SW: begin
                aluSrcImm = 1'b1;
                memWrite = 1'b1;
            end
            mipsPkg::OP_BEQ: begin
                aluOp = mipsPkg::ALU_SUB;
                branch = 1'b1;
            end
            default: ;
        endcase
    end

    registerFile uRegs (
        .clk       (clk),
        .rst_n     (rst_n),
        .writeEn   (regWriteWb),
        .writeAddr (writeRegWb),
        .writeData (writeDataWb),
        .readAddrA (rs),
        .readAddrB (rt),
        .readDataA (readA),
        .readDataB (readB)
    );

    // bubble for a load-use hold or a taken branch
    assign insertBubble = stallDecode || flushExecute;

    ////////////////////
    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regWriteEx <= 1'b0;
            memReadEx <= 1'b0;
            memToRegEx <= 1'b0;
            memWriteEx <= 1'b0;
            branchEx <= 1'b0;
            aluOpEx <= mipsPkg::ALU_ADD;
            aluSrcImmEx <= 1'b0;
            operandAEx <= '0;
            operandBEx <= '0;
            immEx <= '0;
            writeRegEx <= '0;
            rsEx <= '0;
            rtEx <= '0;
            branchTargetEx <= '0;
        end else if (!freeze) begin
            regWriteEx <= regWrite && !insertBubble;
            memReadEx <= memRead && !insertBubble;
            memToRegEx <= memRead && !insertBubble;
            memWriteEx <= memWrite && !insertBubble;
            branchEx <= branch && !insertBubble;
            aluOpEx <= aluOp;
            aluSrcImmEx <= aluSrcImm;
            operandAEx <= readA;
            operandBEx <= readB;
            immEx <= imm;
            writeRegEx <= regDstRd ? rd : rt;
            rsEx <= rs;
            rtEx <= rt;
            branchTargetEx <= pcPlus4 + {imm[mipsPkg::WORD_W-3:0], 2'b00};
        end
    end

endmodule

/* decode/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              writeEn,
    input  mipsPkg::regAddr_t writeAddr,
    input  mipsPkg::word_t    writeData,
    input  mipsPkg::regAddr_t readAddrA,
    input  mipsPkg::regAddr_t readAddrB,
    output mipsPkg::word_t    readDataA,
    output mipsPkg::word_t    readDataB
);

    // register zero has no storage
    mipsPkg::word_t regs [1:mipsPkg::REG_COUNT-1];

    function automatic mipsPkg::word_t readPort(input mipsPkg::regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        // same-cycle write goes straight through
        if (writeEn && writeAddr == addr) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < mipsPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    zeroReadsZero: assert property (@(posedge clk) disable iff (!rst_n)
        (readAddrA == '0 |-> readDataA == '0) and (readAddrB == '0 |-> readDataB == '0));

endmodule

/* execute/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               freeze,
    input  mipsPkg::aluOp_e    aluOpEx,
    input  logic               aluSrcImmEx,
    input  logic               memReadEx,
    input  logic               memWriteEx,
    input  logic               regWriteEx,
    input  logic               branchEx,
    input  logic               memToRegEx,
    input  mipsPkg::word_t     operandAEx,
    input  mipsPkg::word_t     operandBEx,
    input  mipsPkg::word_t     immEx,
    input  mipsPkg::regAddr_t  writeRegEx,
    input  mipsPkg::word_t     branchTargetEx,
    input  mipsPkg::fwdSel_e   fwdA,
    input  mipsPkg::fwdSel_e   fwdB,
    input  mipsPkg::word_t     writeDataWb,
    output logic               branchTaken,
    output mipsPkg::word_t     branchTarget,
    output logic               regWriteMem,
    output mipsPkg::regAddr_t  writeRegMem,
    output logic               memToRegMem,
    output mipsPkg::word_t     aluResultMem,
    output logic               dcacheRen,
    output logic               dcacheWen,
    output mipsPkg::wordAddr_t dcacheAddr,
    output mipsPkg::word_t     dcacheWdata
);

    mipsPkg::word_t srcA, srcBReg, srcB, aluResult;

    function automatic mipsPkg::word_t fwdMux(input mipsPkg::fwdSel_e sel,
                                              input mipsPkg::word_t idEx,
                                              input mipsPkg::word_t memVal,
                                              input mipsPkg::word_t wbVal);
        case (sel)
            mipsPkg::FWD_MEM: return memVal;
            mipsPkg::FWD_WB:  return wbVal;
            default:          return idEx;
        endcase
    endfunction

    ////////////////////
    // operands and ALU
    assign srcA = fwdMux(fwdA, operandAEx, aluResultMem, writeDataWb);
    assign srcBReg = fwdMux(fwdB, operandBEx, aluResultMem, writeDataWb);
    assign srcB = aluSrcImmEx ? immEx : srcBReg;

    always_comb begin
        case (aluOpEx)
            mipsPkg::ALU_SUB: aluResult = srcA - srcB;
            mipsPkg::ALU_AND: aluResult = srcA & srcB;
            mipsPkg::ALU_OR:  aluResult = srcA | srcB;
            // signed compare
            mipsPkg::ALU_SLT: aluResult = mipsPkg::word_t'($signed(srcA) < $signed(srcB));
            default:          aluResult = srcA + srcB;
        endcase
    end

    // beq resolves here on forwarded operands
    assign branchTaken = branchEx && (srcA == srcBReg);
    assign branchTarget = branchTargetEx;

    ////////////////////
    // EX/MEM register, drives the data cache
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regWriteMem <= 1'b0;
            memToRegMem <= 1'b0;
            dcacheRen <= 1'b0;
            dcacheWen <= 1'b0;
            writeRegMem <= '0;
            aluResultMem <= '0;
            dcacheWdata <= '0;
        end else if (!freeze) begin
            regWriteMem <= regWriteEx;
            memToRegMem <= memToRegEx;
            dcacheRen <= memReadEx;
            dcacheWen <= memWriteEx;
            writeRegMem <= writeRegEx;
            aluResultMem <= aluResult;
            dcacheWdata <= srcBReg;
        end
    end

    assign dcacheAddr = aluResultMem[mipsPkg::WORD_W-1:2];

    readWriteExclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheRen && dcacheWen));

endmodule

/* rtl/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               freeze,
    input  logic               stallDecode,
    input  logic               flushDecode,
    input  logic               branchTaken,
    input  mipsPkg::word_t     branchTarget,
    input  mipsPkg::word_t     icacheRdata,
    output mipsPkg::wordAddr_t icacheAddr,
    output mipsPkg::word_t     instr,
    output mipsPkg::word_t     pcPlus4
);

    mipsPkg::word_t pc;
    mipsPkg::word_t pcSeq;
    mipsPkg::word_t pcNext;

    assign pcSeq = pc + mipsPkg::PC_STEP;
    assign pcNext = branchTaken ? branchTarget : pcSeq;
    assign icacheAddr = pc[mipsPkg::WORD_W-1:2];

    // a taken branch wins over a load-use hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= mipsPkg::RESET_PC;
        end else if (!freeze && (branchTaken || !stallDecode)) begin
            pc <= pcNext;
        end
    end

    ////////////////////
    // IF/ID register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr <= '0;
            pcPlus4 <= '0;
        end else if (!freeze) begin
            if (flushDecode) begin
                // all zero decodes as a no-op
                instr <= '0;
                pcPlus4 <= '0;
            end else if (!stallDecode) begin
                instr <= icacheRdata;
                pcPlus4 <= pcSeq;
            end
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    input  mipsPkg::word_t    instr,
    input  logic              memToRegEx,
    input  mipsPkg::regAddr_t writeRegEx,
    input  mipsPkg::regAddr_t rsEx,
    input  mipsPkg::regAddr_t rtEx,
    input  logic              regWriteMem,
    input  mipsPkg::regAddr_t writeRegMem,
    input  logic              regWriteWb,
    input  mipsPkg::regAddr_t writeRegWb,
    input  logic              branchTaken,
    output logic              stallDecode,
    output logic              flushDecode,
    output logic              flushExecute,
    output mipsPkg::fwdSel_e  fwdA,
    output mipsPkg::fwdSel_e  fwdB
);

    mipsPkg::regAddr_t rsDecode, rtDecode;

    // memory stage is younger, so it wins
    function automatic mipsPkg::fwdSel_e pickFwd(input mipsPkg::regAddr_t src);
        if (src == '0) begin
            return mipsPkg::FWD_NONE;
        end
        if (regWriteMem && writeRegMem == src) begin
            return mipsPkg::FWD_MEM;
        end
        if (regWriteWb && writeRegWb == src) begin
            return mipsPkg::FWD_WB;
        end
        return mipsPkg::FWD_NONE;
    endfunction

    assign rsDecode = instr[mipsPkg::RS_HI:mipsPkg::RS_LO];
    assign rtDecode = instr[mipsPkg::RT_HI:mipsPkg::RT_LO];

    ////////////////////
    // load-use and branch
    assign stallDecode = memToRegEx && writeRegEx != '0 &&
                         (writeRegEx == rsDecode || writeRegEx == rtDecode);
    assign flushDecode = branchTaken;
    assign flushExecute = branchTaken;

    always_comb begin
        fwdA = pickFwd(rsEx);
        fwdB = pickFwd(rtEx);
    end

endmodule

/* rtl/mipsPipeline.sv */
`timescale 1ns/1ps

module mipsPipeline (
    input  logic               clk,
    input  logic               rst_n,
    output mipsPkg::wordAddr_t icacheAddr,
    input  mipsPkg::word_t     icacheRdata,
    input  logic               icacheStall,
    output logic               dcacheRen,
    output logic               dcacheWen,
    output mipsPkg::wordAddr_t dcacheAddr,
    output mipsPkg::word_t     dcacheWdata,
    input  mipsPkg::word_t     dcacheRdata,
    input  logic               dcacheStall
);

    ////////////////////
    // stage to stage wires
    logic freeze;

    mipsPkg::word_t instr;
    mipsPkg::word_t pcPlus4;

    mipsPkg::aluOp_e aluOpEx;
    logic aluSrcImmEx, memReadEx, memWriteEx, regWriteEx, branchEx, memToRegEx;
    mipsPkg::word_t operandAEx, operandBEx, immEx, branchTargetEx;
    mipsPkg::regAddr_t writeRegEx, rsEx, rtEx;

    logic branchTaken;
    mipsPkg::word_t branchTarget;
    logic regWriteMem, memToRegMem;
    mipsPkg::regAddr_t writeRegMem;
    mipsPkg::word_t aluResultMem;

    logic regWriteWb;
    mipsPkg::regAddr_t writeRegWb;
    mipsPkg::word_t writeDataWb;

    logic stallDecode, flushDecode, flushExecute;
    mipsPkg::fwdSel_e fwdA, fwdB;

    // any cache miss holds the whole pipe
    assign freeze = icacheStall | dcacheStall;

    ////////////////////
    // stages
    fetchStage uFetch (.*);

    decodeStage uDecode (.*);

    executeStage uExecute (.*);

    writebackStage uWriteback (.*);

    hazardUnit uHazard (.*);

endmodule

/* rtl/writebackStage.sv */
`timescale 1ns/1ps

module writebackStage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              freeze,
    input  logic              regWriteMem,
    input  mipsPkg::regAddr_t writeRegMem,
    input  logic              memToRegMem,
    input  mipsPkg::word_t    aluResultMem,
    input  mipsPkg::word_t    dcacheRdata,
    output logic              regWriteWb,
    output mipsPkg::regAddr_t writeRegWb,
    output mipsPkg::word_t    writeDataWb
);

    logic memToRegWb;
    mipsPkg::word_t aluResultWb;
    mipsPkg::word_t loadDataWb;

    ////////////////////
    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regWriteWb <= 1'b0;
            memToRegWb <= 1'b0;
            writeRegWb <= '0;
            aluResultWb <= '0;
            loadDataWb <= '0;
        end else if (!freeze) begin
            regWriteWb <= regWriteMem;
            memToRegWb <= memToRegMem;
            writeRegWb <= writeRegMem;
            aluResultWb <= aluResultMem;
            // read data only valid with both caches ready
            loadDataWb <= dcacheRdata;
        end
    end

    assign writeDataWb = memToRegWb ? loadDataWb : aluResultWb;

endmodule

/* sim/tbMipsPipeline.sv */
`timescale 1ns/1ps

module tbMipsPipeline;

    localparam int CLK_PERIOD = 40;
    localparam int SEED = 93710;
    localparam int RANDOM_LEN = 64;
    // random part, seven stores, closing self loop
    localparam int PROG_LEN = RANDOM_LEN + 8;
    localparam int DMEM_WORDS = 16;
    localparam int ISTALL_PCT = 20;
    localparam int DSTALL_PCT = 15;
    // two runs of the program
    localparam int TIMEOUT_CYCLES = 2 * PROG_LEN * 40;

    logic clk, rst_n, icacheStall, dcacheStall, dcacheRen, dcacheWen;
    mipsPkg::wordAddr_t icacheAddr, dcacheAddr;
    mipsPkg::word_t icacheRdata, dcacheWdata, dcacheRdata;
    mipsPkg::word_t imem [PROG_LEN];
    mipsPkg::word_t dmem [DMEM_WORDS];
    bit expIsStore [$];
    mipsPkg::wordAddr_t expAddr [$];
    mipsPkg::word_t expData [$];
    int expIdx, storeErrors, loadErrors, otherErrors;
    bit stallsOn;

    mipsPipeline u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // cache models
    assign icacheRdata = (icacheAddr < PROG_LEN) ? imem[icacheAddr[6:0]] : '0;
    assign dcacheRdata = dmem[dcacheAddr[3:0]];

    always @(negedge clk) begin
        icacheStall = stallsOn && ($urandom % 100 < ISTALL_PCT);
        dcacheStall = stallsOn && ($urandom % 100 < DSTALL_PCT);
    end

    function automatic mipsPkg::word_t fillWord(input int idx);
        return 32'hC0DE0000 + idx * 32'h00010101;
    endfunction

    task automatic compareStore(input mipsPkg::wordAddr_t addr, input mipsPkg::word_t data);
        if (expIdx >= expAddr.size()) begin
            $display("store to word address %h after the last expected access", addr);
            otherErrors++;
        end else begin
            if (!expIsStore[expIdx]) begin
                $display("a store committed where the model expects a load, access %0d", expIdx);
                otherErrors++;
            end
            if (addr !== expAddr[expIdx] || data !== expData[expIdx]) begin
                $display("CHECK FAILED dcacheAddr/dcacheWdata expected %h/%h got %h/%h",
                         expAddr[expIdx], expData[expIdx], addr, data);
                storeErrors++;
            end
            expIdx++;
        end
    endtask

    task automatic compareLoad(input mipsPkg::wordAddr_t addr);
        if (expIdx >= expAddr.size()) begin
            $display("load from word address %h after the last expected access", addr);
            otherErrors++;
        end else begin
            if (expIsStore[expIdx]) begin
                $display("a load committed where the model expects a store, access %0d", expIdx);
                otherErrors++;
            end
            if (addr !== expAddr[expIdx]) begin
                $display("CHECK FAILED dcacheAddr expected %h got %h", expAddr[expIdx], addr);
                loadErrors++;
            end
            expIdx++;
        end
    endtask

    task automatic compareFetch(input mipsPkg::wordAddr_t expected);
        if (icacheAddr !== expected) begin
            $display("CHECK FAILED icacheAddr expected %h got %h", expected, icacheAddr);
            otherErrors++;
        end
    endtask

    // commit point: access seen on an edge with both caches ready
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (!icacheStall && !dcacheStall) begin
            if (dcacheWen) begin
                compareStore(dcacheAddr, dcacheWdata);
                dmem[dcacheAddr[3:0]] <= dcacheWdata;
            end else if (dcacheRen) begin
                compareLoad(dcacheAddr);
            end
        end
    end

    ////////////////////
    // program and reference model
    function automatic mipsPkg::word_t iType(input mipsPkg::opcode_e op, input int rs,
                                             input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic void buildProgram();
        mipsPkg::funct_e fns [5] = '{mipsPkg::FN_ADD, mipsPkg::FN_SUB, mipsPkg::FN_AND,
                                     mipsPkg::FN_OR, mipsPkg::FN_SLT};
        int kind, rs, rt, rd;
        for (int i = 0; i < RANDOM_LEN; i++) begin
            kind = $urandom % 9;
            rs = $urandom % 8;
            rt = 1 + $urandom % 7;
            rd = 1 + $urandom % 7;
            // a late branch would skip the closing stores
            if (kind == 8 && i >= RANDOM_LEN - 3) begin
                kind = 5;
            end
            case (kind)
                5: imem[i] = iType(mipsPkg::OP_ADDI, rs, rt, 16'($urandom));
                6: imem[i] = iType(mipsPkg::OP_LW, rs, rt, 16'(($urandom % 16) * 4));
                7: imem[i] = iType(mipsPkg::OP_SW, rs, rt, 16'(($urandom % 16) * 4));
                8: imem[i] = iType(mipsPkg::OP_BEQ, rs, $urandom % 8, 16'(1 + $urandom % 3));
                default: imem[i] = {mipsPkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fns[kind]};
            endcase
        end
        for (int r = 1; r < 8; r++) begin
            imem[RANDOM_LEN + r - 1] = iType(mipsPkg::OP_SW, 0, r, 16'(r * 4));
        end
        imem[PROG_LEN - 1] = iType(mipsPkg::OP_BEQ, 0, 0, 16'hFFFF);
    endfunction

    function automatic void runModel();
        mipsPkg::word_t r [8];
        mipsPkg::word_t mem [DMEM_WORDS];
        mipsPkg::word_t ins, a, b, simm, addr;
        int pc;
        for (int i = 0; i < 8; i++) begin
            r[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem[i] = fillWord(i);
        end
        pc = 0;
        while (pc != PROG_LEN - 1) begin
            ins = imem[pc];
            // only registers 0 to 7 appear
            a = r[ins[23:21]];
            b = r[ins[18:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = a + simm;
            pc++;
            case (ins[31:26])
                mipsPkg::OP_RTYPE: begin
                    case (ins[5:0])
                        mipsPkg::FN_ADD: r[ins[13:11]] = a + b;
                        mipsPkg::FN_SUB: r[ins[13:11]] = a - b;
                        mipsPkg::FN_AND: r[ins[13:11]] = a & b;
                        mipsPkg::FN_OR:  r[ins[13:11]] = a | b;
                        mipsPkg::FN_SLT: r[ins[13:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
                        default: ;
                    endcase
                end
                mipsPkg::OP_ADDI: r[ins[18:16]] = addr;
                mipsPkg::OP_LW: begin
                    expIsStore.push_back(1'b0);
                    expAddr.push_back(addr[31:2]);
                    expData.push_back(mem[addr[5:2]]);
                    r[ins[18:16]] = mem[addr[5:2]];
                end
                mipsPkg::OP_SW: begin
                    expIsStore.push_back(1'b1);
                    expAddr.push_back(addr[31:2]);
                    expData.push_back(b);
                    mem[addr[5:2]] = b;
                end
                mipsPkg::OP_BEQ: if (a == b) pc = pc + int'($signed(simm));
                default: ;
            endcase
            r[0] = '0;
        end
    endfunction

    ////////////////////
    // runs
    task automatic runProgram(input bit withStalls);
        stallsOn = 1'b0;
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        expIdx = 0;
        rst_n = 1'b1;
        if (dcacheRen !== 1'b0 || dcacheWen !== 1'b0) begin
            $display("CHECK FAILED dcacheRen/dcacheWen expected 0/0 got %h/%h",
                     dcacheRen, dcacheWen);
            otherErrors++;
        end
        compareFetch('0);
        stallsOn = withStalls;
        wait (expIdx == expAddr.size());
        // the self loop must not produce further accesses
        repeat (40) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
        stallsOn = 1'b0;
        void'($urandom(SEED));
        buildProgram();
        runModel();
        runProgram(1'b0);
        runProgram(1'b1);
        $display("errors: store %0d, load %0d, other %0d", storeErrors, loadErrors, otherErrors);
        if (storeErrors + loadErrors + otherErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired, %0d of %0d accesses seen", expIdx, expAddr.size());
        $display("Test FAILED");
        $finish;
    end

endmodule
